// ==== logic/rv32_isa_pkg.sv ====
`default_nettype none

package rv32_isa_pkg;

    // Data and address word
    typedef logic [31:0] word_t;

    // Architectural register index
    typedef logic [4:0] reg_idx_t;

    // Access size and signedness, encoded like funct3 of the load opcode
    typedef enum logic [2:0] {
        LB   = 3'b000,
        LH   = 3'b001,
        LW   = 3'b010,
        LBU  = 3'b100,
        LHU  = 3'b101,
        NONE = 3'b111
    } load_type_t;

    // Writeback source
    typedef enum logic [1:0] {
        W_SEL_DLOAD = 2'b00,
        W_SEL_PC    = 2'b01,
        W_SEL_IMM_U = 2'b10,
        W_SEL_ALU   = 2'b11
    } w_sel_t;

endpackage

`default_nettype wire

// ==== logic/dbus_pkg.sv ====
`default_nettype none

package dbus_pkg;

    // Lane mask, bit n covers bits 8n+7 down to 8n
    typedef logic [3:0] byte_en_t;

    // Word index of a 32-bit byte address
    // The scratchpad only decodes its low ADDR_BITS
    typedef logic [29:0] word_addr_t;

    // Four-phase requester states
    typedef enum logic [1:0] {
        IDLE    = 2'b00,
        REQ     = 2'b01,
        RELEASE = 2'b10,
        DONE    = 2'b11
    } dbus_state_t;

endpackage

`default_nettype wire

// ==== logic/load_extender.sv ====
`timescale 1ns/10ps
`default_nettype none

module load_extender (
    input  rv32_isa_pkg::word_t      word_in,
    input  rv32_isa_pkg::load_type_t load_type,
    input  dbus_pkg::byte_en_t       byte_en,
    output rv32_isa_pkg::word_t      ext_out
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    // Move the enabled lane(s) down to bit 0
    always_comb begin
        case (byte_en)
            4'b0001: byte_sel = word_in[7:0];
            4'b0010: byte_sel = word_in[15:8];
            4'b0100: byte_sel = word_in[23:16];
            4'b1000: byte_sel = word_in[31:24];
            default: byte_sel = 8'h00;
        endcase

        case (byte_en)
            4'b0011: half_sel = word_in[15:0];
            4'b1100: half_sel = word_in[31:16];
            default: half_sel = 16'h0000;
        endcase
    end

    always_comb begin
        case (load_type)
            rv32_isa_pkg::LB:  ext_out = {{24{byte_sel[7]}}, byte_sel};
            rv32_isa_pkg::LBU: ext_out = {24'h000000, byte_sel};
            rv32_isa_pkg::LH:  ext_out = {{16{half_sel[15]}}, half_sel};
            rv32_isa_pkg::LHU: ext_out = {16'h0000, half_sel};
            rv32_isa_pkg::LW:  ext_out = word_in;
            default:           ext_out = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/fence_tracker.sv ====
`timescale 1ns/10ps
`default_nettype none

module fence_tracker (
    input  logic CLK,
    input  logic nRST,
    input  logic ifence,
    input  logic iflush_done,
    input  logic dflush_done,
    output logic flush,
    output logic fence_stall
);

    logic ifence_q;
    logic iflushed;
    logic dflushed;

    // One pulse on the first cycle of a held request
    assign flush = ifence & ~ifence_q;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ifence_q <= 1'b0;
        end else begin
            ifence_q <= ifence;
        end
    end

    // Both caches count as flushed out of reset
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            iflushed <= 1'b1;
            dflushed <= 1'b1;
        end else begin
            if (flush) begin
                iflushed <= 1'b0;
            end else if (iflush_done) begin
                iflushed <= 1'b1;
            end

            if (flush) begin
                dflushed <= 1'b0;
            end else if (dflush_done) begin
                dflushed <= 1'b1;
            end
        end
    end

    // Pulse cycle counts too, flags only clear on the following edge
    assign fence_stall = flush | ~(iflushed & dflushed);

endmodule

`default_nettype wire

// ==== logic/dbus_master.sv ====
`timescale 1ns/10ps
`default_nettype none

module dbus_master (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                op_start,
    input  logic                op_we,
    input  dbus_pkg::byte_en_t  op_byte_en,
    input  rv32_isa_pkg::word_t op_addr,
    input  rv32_isa_pkg::word_t op_wdata,
    input  logic                ack,
    input  rv32_isa_pkg::word_t bus_rdata,
    output logic                op_complete,
    output rv32_isa_pkg::word_t op_rdata,
    output logic                req,
    output logic                we,
    output dbus_pkg::byte_en_t  byte_en,
    output rv32_isa_pkg::word_t bus_addr,
    output rv32_isa_pkg::word_t bus_wdata
);

    dbus_pkg::dbus_state_t state;
    dbus_pkg::dbus_state_t next_state;

    always_comb begin
        next_state = state;
        case (state)
            dbus_pkg::IDLE:    if (op_start) next_state = dbus_pkg::REQ;
            dbus_pkg::REQ:     if (ack) next_state = dbus_pkg::RELEASE;
            dbus_pkg::RELEASE: if (!ack) next_state = dbus_pkg::DONE;
            default:           next_state = dbus_pkg::IDLE;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= dbus_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    assign req         = (state == dbus_pkg::REQ);
    assign op_complete = (state == dbus_pkg::DONE);

    // Operands frozen for the whole handshake
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            we      <= 1'b0;
            byte_en <= '0;
        end else if (state == dbus_pkg::IDLE && op_start) begin
            we      <= op_we;
            byte_en <= op_byte_en;
        end
    end

    always_ff @(posedge CLK) begin
        if (state == dbus_pkg::IDLE && op_start) begin
            bus_addr  <= op_addr;
            bus_wdata <= op_wdata;
        end
    end

    // Read word is valid while ack is high
    always_ff @(posedge CLK) begin
        if (state == dbus_pkg::REQ && ack) begin
            op_rdata <= bus_rdata;
        end
    end

endmodule

`default_nettype wire

// ==== logic/mem_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_stage (
    input  logic                     CLK,
    input  logic                     nRST,
    input  logic                     valid,
    input  logic                     dren,
    input  logic                     dwen,
    input  rv32_isa_pkg::load_type_t load_type,
    input  rv32_isa_pkg::word_t      addr,
    input  rv32_isa_pkg::word_t      store_data,
    input  rv32_isa_pkg::w_sel_t     w_sel,
    input  rv32_isa_pkg::word_t      pc4,
    input  rv32_isa_pkg::word_t      imm_u,
    input  logic                     ifence,
    input  logic                     iflush_done,
    input  logic                     dflush_done,
    input  logic                     ack,
    input  rv32_isa_pkg::word_t      bus_rdata,
    output logic                     stall,
    output logic                     reg_write_en,
    output rv32_isa_pkg::word_t      reg_wdata,
    output logic                     mal_load,
    output logic                     mal_store,
    output logic                     flush,
    output logic                     req,
    output logic                     we,
    output dbus_pkg::byte_en_t       byte_en,
    output rv32_isa_pkg::word_t      bus_addr,
    output rv32_isa_pkg::word_t      bus_wdata
);

    dbus_pkg::byte_en_t  lane_en;
    rv32_isa_pkg::word_t store_wdata;
    rv32_isa_pkg::word_t op_rdata;
    rv32_isa_pkg::word_t dload_ext;
    logic                mal_addr;
    logic                op_start;
    logic                op_complete;
    logic                fence_stall;

    // Lane mask from size and low address bits
    always_comb begin
        case (load_type)
            rv32_isa_pkg::LB, rv32_isa_pkg::LBU: begin
                lane_en = dbus_pkg::byte_en_t'(4'b0001 << addr[1:0]);
            end
            rv32_isa_pkg::LH, rv32_isa_pkg::LHU: begin
                lane_en = addr[1] ? 4'b1100 : 4'b0011;
            end
            rv32_isa_pkg::LW: lane_en = 4'b1111;
            default:          lane_en = 4'b0000;
        endcase
    end

    always_comb begin
        case (load_type)
            rv32_isa_pkg::LW:                    mal_addr = (addr[1:0] != 2'b00);
            rv32_isa_pkg::LH, rv32_isa_pkg::LHU: mal_addr = addr[0];
            default:                             mal_addr = 1'b0;
        endcase
    end

    assign mal_load  = valid & dren & mal_addr;
    assign mal_store = valid & dwen & mal_addr;

    // Replicate narrow stores so every lane carries the value
    always_comb begin
        case (load_type)
            rv32_isa_pkg::LB: store_wdata = {4{store_data[7:0]}};
            rv32_isa_pkg::LH: store_wdata = {2{store_data[15:0]}};
            default:          store_wdata = store_data;
        endcase
    end

    assign op_start = valid & (dren | dwen) & ~mal_addr;

    dbus_master u_dbus_master (
        .CLK         (CLK),
        .nRST        (nRST),
        .op_start    (op_start),
        .op_we       (dwen),
        .op_byte_en  (lane_en),
        .op_addr     (addr),
        .op_wdata    (store_wdata),
        .ack         (ack),
        .bus_rdata   (bus_rdata),
        .op_complete (op_complete),
        .op_rdata    (op_rdata),
        .req         (req),
        .we          (we),
        .byte_en     (byte_en),
        .bus_addr    (bus_addr),
        .bus_wdata   (bus_wdata)
    );

    load_extender u_load_extender (
        .word_in   (op_rdata),
        .load_type (load_type),
        .byte_en   (lane_en),
        .ext_out   (dload_ext)
    );

    fence_tracker u_fence_tracker (
        .CLK         (CLK),
        .nRST        (nRST),
        .ifence      (valid & ifence),
        .iflush_done (iflush_done),
        .dflush_done (dflush_done),
        .flush       (flush),
        .fence_stall (fence_stall)
    );

    // Hold until the transfer reports done or the fence clears
    assign stall = (op_start & ~op_complete) | fence_stall;

    assign reg_write_en = valid & ~dwen & ~mal_load;

    always_comb begin
        case (w_sel)
            rv32_isa_pkg::W_SEL_DLOAD: reg_wdata = dload_ext;
            rv32_isa_pkg::W_SEL_PC:    reg_wdata = pc4;
            rv32_isa_pkg::W_SEL_IMM_U: reg_wdata = imm_u;
            rv32_isa_pkg::W_SEL_ALU:   reg_wdata = addr;
            default:                   reg_wdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/scratchpad_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module scratchpad_ram #(
    parameter int ADDR_BITS = 8,
    parameter int ACK_DELAY = 2
) (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                req,
    input  logic                we,
    input  dbus_pkg::byte_en_t  byte_en,
    input  rv32_isa_pkg::word_t bus_addr,
    input  rv32_isa_pkg::word_t bus_wdata,
    output logic                ack,
    output rv32_isa_pkg::word_t bus_rdata
);

    localparam int CNT_BITS = (ACK_DELAY > 1) ? $clog2(ACK_DELAY) : 1;
    localparam logic [CNT_BITS-1:0] LAST_CNT = CNT_BITS'(ACK_DELAY - 1);

    rv32_isa_pkg::word_t  mem [2**ADDR_BITS];
    dbus_pkg::word_addr_t widx;
    logic [CNT_BITS-1:0]  cnt;
    logic                 ack_rise;

    // Byte offset bits are ignored, lanes come from byte_en
    assign widx     = bus_addr[31:2];
    assign ack_rise = req & ~ack & (cnt == LAST_CNT);

    // Delay counter and ack
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ack <= 1'b0;
            cnt <= '0;
        end else if (!req) begin
            ack <= 1'b0;
            cnt <= '0;
        end else if (ack_rise) begin
            ack <= 1'b1;
            cnt <= '0;
        end else if (!ack) begin
            cnt <= cnt + 1'b1;
        end
    end

    // Access happens on the edge that raises ack
    always_ff @(posedge CLK) begin
        if (ack_rise) begin
            if (we) begin
                for (int i = 0; i < 4; i++) begin
                    if (byte_en[i]) begin
                        mem[widx[ADDR_BITS-1:0]][8*i +: 8] <= bus_wdata[8*i +: 8];
                    end
                end
            end
            bus_rdata <= mem[widx[ADDR_BITS-1:0]];
        end
    end

endmodule

`default_nettype wire

// ==== logic/mem_subsystem.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_subsystem #(
    parameter int ADDR_BITS = 8,
    parameter int ACK_DELAY = 2
) (
    input  logic                     CLK,
    input  logic                     nRST,
    input  logic                     valid,
    input  logic                     dren,
    input  logic                     dwen,
    input  rv32_isa_pkg::load_type_t load_type,
    input  rv32_isa_pkg::word_t      addr,
    input  rv32_isa_pkg::word_t      store_data,
    input  rv32_isa_pkg::w_sel_t     w_sel,
    input  rv32_isa_pkg::word_t      pc4,
    input  rv32_isa_pkg::word_t      imm_u,
    input  logic                     ifence,
    input  logic                     iflush_done,
    input  logic                     dflush_done,
    output logic                     stall,
    output logic                     reg_write_en,
    output rv32_isa_pkg::word_t      reg_wdata,
    output logic                     mal_load,
    output logic                     mal_store,
    output logic                     icache_flush,
    output logic                     dcache_flush
);

    logic                flush;
    logic                req;
    logic                we;
    logic                ack;
    dbus_pkg::byte_en_t  byte_en;
    rv32_isa_pkg::word_t bus_addr;
    rv32_isa_pkg::word_t bus_wdata;
    rv32_isa_pkg::word_t bus_rdata;

    // Same pulse to both caches
    assign icache_flush = flush;
    assign dcache_flush = flush;

    mem_stage u_mem_stage (
        .CLK          (CLK),
        .nRST         (nRST),
        .valid        (valid),
        .dren         (dren),
        .dwen         (dwen),
        .load_type    (load_type),
        .addr         (addr),
        .store_data   (store_data),
        .w_sel        (w_sel),
        .pc4          (pc4),
        .imm_u        (imm_u),
        .ifence       (ifence),
        .iflush_done  (iflush_done),
        .dflush_done  (dflush_done),
        .ack          (ack),
        .bus_rdata    (bus_rdata),
        .stall        (stall),
        .reg_write_en (reg_write_en),
        .reg_wdata    (reg_wdata),
        .mal_load     (mal_load),
        .mal_store    (mal_store),
        .flush        (flush),
        .req          (req),
        .we           (we),
        .byte_en      (byte_en),
        .bus_addr     (bus_addr),
        .bus_wdata    (bus_wdata)
    );

    scratchpad_ram #(
        .ADDR_BITS (ADDR_BITS),
        .ACK_DELAY (ACK_DELAY)
    ) u_scratchpad_ram (
        .CLK       (CLK),
        .nRST      (nRST),
        .req       (req),
        .we        (we),
        .byte_en   (byte_en),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .ack       (ack),
        .bus_rdata (bus_rdata)
    );

endmodule

`default_nettype wire

// ==== verif/mem_subsystem_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_subsystem_tb;

    localparam int ADDR_BITS = 8;
    localparam int ACK_DELAY = 2;
    localparam int MAX_ROWS  = 48;

    // One held instruction and what the stage should answer
    typedef struct packed {
        logic                     dren;
        logic                     dwen;
        rv32_isa_pkg::load_type_t load_type;
        rv32_isa_pkg::word_t      addr;
        rv32_isa_pkg::word_t      store_data;
        rv32_isa_pkg::w_sel_t     w_sel;
        rv32_isa_pkg::word_t      pc4;
        rv32_isa_pkg::word_t      imm_u;
        logic                     ifence;
        logic                     exp_wen;
        rv32_isa_pkg::word_t      exp_wdata;
        logic                     chk_wdata;
        logic                     exp_mal_load;
        logic                     exp_mal_store;
    } row_t;

    logic                     CLK;
    logic                     nRST;
    logic                     valid;
    logic                     dren;
    logic                     dwen;
    rv32_isa_pkg::load_type_t load_type;
    rv32_isa_pkg::word_t      addr;
    rv32_isa_pkg::word_t      store_data;
    rv32_isa_pkg::w_sel_t     w_sel;
    rv32_isa_pkg::word_t      pc4;
    rv32_isa_pkg::word_t      imm_u;
    logic                     ifence;
    logic                     iflush_done;
    logic                     dflush_done;
    logic                     stall;
    logic                     reg_write_en;
    rv32_isa_pkg::word_t      reg_wdata;
    logic                     mal_load;
    logic                     mal_store;
    logic                     icache_flush;
    logic                     dcache_flush;

    row_t       rows [0:MAX_ROWS-1];
    string      row_name [0:MAX_ROWS-1];
    int         n_rows;
    logic [7:0] model_mem [0:1023];
    int         pass_count;
    int         fail_count;
    int         timeout_limit;
    int         cycle_count;
    int         iflush_pulses;
    int         dflush_pulses;
    logic       idone_seen;
    logic       ddone_seen;
    integer     seed;

    mem_subsystem #(
        .ADDR_BITS (ADDR_BITS),
        .ACK_DELAY (ACK_DELAY)
    ) UUT (
        .CLK          (CLK),
        .nRST         (nRST),
        .valid        (valid),
        .dren         (dren),
        .dwen         (dwen),
        .load_type    (load_type),
        .addr         (addr),
        .store_data   (store_data),
        .w_sel        (w_sel),
        .pc4          (pc4),
        .imm_u        (imm_u),
        .ifence       (ifence),
        .iflush_done  (iflush_done),
        .dflush_done  (dflush_done),
        .stall        (stall),
        .reg_write_en (reg_write_en),
        .reg_wdata    (reg_wdata),
        .mal_load     (mal_load),
        .mal_store    (mal_store),
        .icache_flush (icache_flush),
        .dcache_flush (dcache_flush)
    );

    initial begin
        CLK = 1'b0;
        forever begin
            #4 CLK = ~CLK;
        end
    end

    // Little-endian byte model of the scratchpad
    function automatic rv32_isa_pkg::word_t model_load(input rv32_isa_pkg::load_type_t lt,
                                                       input rv32_isa_pkg::word_t a);
        rv32_isa_pkg::word_t w;
        logic [9:0]          base;
        base = a[9:0];
        for (int k = 0; k < 4; k++) begin
            w[8*k +: 8] = model_mem[base + 10'(k)];
        end
        case (lt)
            rv32_isa_pkg::LB:  return {{24{w[7]}}, w[7:0]};
            rv32_isa_pkg::LBU: return {24'h000000, w[7:0]};
            rv32_isa_pkg::LH:  return {{16{w[15]}}, w[15:0]};
            rv32_isa_pkg::LHU: return {16'h0000, w[15:0]};
            default:           return w;
        endcase
    endfunction

    task automatic model_store(input rv32_isa_pkg::load_type_t lt, input rv32_isa_pkg::word_t a,
                               input rv32_isa_pkg::word_t sd);
        int         nbytes;
        logic [9:0] base;
        base = a[9:0];
        nbytes = (lt == rv32_isa_pkg::LB) ? 1 : (lt == rv32_isa_pkg::LH) ? 2 : 4;
        for (int k = 0; k < nbytes; k++) begin
            model_mem[base + 10'(k)] = sd[8*k +: 8];
        end
    endtask

    task automatic add_row(input string name, input logic rd, input logic wr,
                           input rv32_isa_pkg::load_type_t lt, input rv32_isa_pkg::word_t a,
                           input rv32_isa_pkg::word_t sd, input rv32_isa_pkg::w_sel_t ws,
                           input rv32_isa_pkg::word_t p4, input rv32_isa_pkg::word_t iu,
                           input logic fen);
        row_t                r;
        logic                mis;
        rv32_isa_pkg::word_t load_val;
        mis = ((lt == rv32_isa_pkg::LW) && (a[1:0] != 2'b00))
            || (((lt == rv32_isa_pkg::LH) || (lt == rv32_isa_pkg::LHU)) && a[0]);
        load_val = (rd && !mis) ? model_load(lt, a) : 32'h0;
        r.dren          = rd;
        r.dwen          = wr;
        r.load_type     = lt;
        r.addr          = a;
        r.store_data    = sd;
        r.w_sel         = ws;
        r.pc4           = p4;
        r.imm_u         = iu;
        r.ifence        = fen;
        r.exp_mal_load  = rd & mis;
        r.exp_mal_store = wr & mis;
        r.exp_wen       = !wr && !(rd && mis);
        r.chk_wdata     = r.exp_wen;
        case (ws)
            rv32_isa_pkg::W_SEL_DLOAD: r.exp_wdata = load_val;
            rv32_isa_pkg::W_SEL_PC:    r.exp_wdata = p4;
            rv32_isa_pkg::W_SEL_IMM_U: r.exp_wdata = iu;
            default:                   r.exp_wdata = a;
        endcase
        // Memory only changes for aligned stores
        if (wr && !mis) begin
            model_store(lt, a, sd);
        end
        rows[n_rows] = r;
        row_name[n_rows] = name;
        n_rows++;
    endtask

    task automatic add_store(input string name, input rv32_isa_pkg::load_type_t lt,
                             input rv32_isa_pkg::word_t a, input rv32_isa_pkg::word_t sd);
        add_row(name, 1'b0, 1'b1, lt, a, sd, rv32_isa_pkg::W_SEL_ALU, 32'h0, 32'h0, 1'b0);
    endtask

    task automatic add_load(input string name, input rv32_isa_pkg::load_type_t lt,
                            input rv32_isa_pkg::word_t a);
        add_row(name, 1'b1, 1'b0, lt, a, 32'hffff_ffff, rv32_isa_pkg::W_SEL_DLOAD,
                32'h0000_1004, 32'hcafe_0000, 1'b0);
    endtask

    task automatic add_other(input string name, input rv32_isa_pkg::w_sel_t ws,
                             input rv32_isa_pkg::word_t a, input logic fen);
        add_row(name, 1'b0, 1'b0, rv32_isa_pkg::NONE, a, 32'h0, ws,
                32'h0000_2468, 32'h1234_5000, fen);
    endtask

    task automatic build_table;
        add_store("sw", rv32_isa_pkg::LW, 32'h010, 32'hdead_beef);
        add_load("lw", rv32_isa_pkg::LW, 32'h010);
        // Byte lanes, one offset each
        add_store("sw init", rv32_isa_pkg::LW, 32'h020, 32'h0000_0000);
        add_store("sb +0", rv32_isa_pkg::LB, 32'h020, 32'h0000_0081);
        add_store("sb +1", rv32_isa_pkg::LB, 32'h021, 32'h1234_567f);
        add_store("sb +2", rv32_isa_pkg::LB, 32'h022, 32'h0000_00a5);
        add_store("sb +3", rv32_isa_pkg::LB, 32'h023, 32'hffff_ff3c);
        add_load("lb +0", rv32_isa_pkg::LB, 32'h020);
        add_load("lbu +0", rv32_isa_pkg::LBU, 32'h020);
        add_load("lb +1", rv32_isa_pkg::LB, 32'h021);
        add_load("lb +2", rv32_isa_pkg::LB, 32'h022);
        add_load("lbu +2", rv32_isa_pkg::LBU, 32'h022);
        add_load("lbu +3", rv32_isa_pkg::LBU, 32'h023);
        add_load("lw bytes", rv32_isa_pkg::LW, 32'h020);
        // Half lanes
        add_store("sw init", rv32_isa_pkg::LW, 32'h030, 32'h0000_0000);
        add_store("sh +0", rv32_isa_pkg::LH, 32'h030, 32'hffff_8001);
        add_store("sh +2", rv32_isa_pkg::LH, 32'h032, 32'h0000_7ffe);
        add_load("lh +0", rv32_isa_pkg::LH, 32'h030);
        add_load("lhu +0", rv32_isa_pkg::LHU, 32'h030);
        add_load("lh +2", rv32_isa_pkg::LH, 32'h032);
        add_load("lhu +2", rv32_isa_pkg::LHU, 32'h032);
        add_load("lb +1", rv32_isa_pkg::LB, 32'h031);
        add_load("lw halves", rv32_isa_pkg::LW, 32'h030);
        // Misaligned accesses leave memory alone
        add_load("lw mal", rv32_isa_pkg::LW, 32'h011);
        add_load("lh mal", rv32_isa_pkg::LH, 32'h033);
        add_store("sw mal", rv32_isa_pkg::LW, 32'h012, 32'h1111_1111);
        add_load("lw after", rv32_isa_pkg::LW, 32'h010);
        add_other("pc4", rv32_isa_pkg::W_SEL_PC, 32'h0000_0040, 1'b0);
        add_other("imm_u", rv32_isa_pkg::W_SEL_IMM_U, 32'h0000_0044, 1'b0);
        add_other("alu", rv32_isa_pkg::W_SEL_ALU, 32'h8765_4321, 1'b0);
        add_other("fence", rv32_isa_pkg::W_SEL_ALU, 32'h0000_0abc, 1'b1);
        add_load("lw post", rv32_isa_pkg::LW, 32'h020);
        add_other("fence", rv32_isa_pkg::W_SEL_PC, 32'h0000_0def, 1'b1);
        add_load("lh post", rv32_isa_pkg::LH, 32'h032);
    endtask

    task automatic drive_row(input int idx);
        valid      <= 1'b1;
        dren       <= rows[idx].dren;
        dwen       <= rows[idx].dwen;
        load_type  <= rows[idx].load_type;
        addr       <= rows[idx].addr;
        store_data <= rows[idx].store_data;
        w_sel      <= rows[idx].w_sel;
        pc4        <= rows[idx].pc4;
        imm_u      <= rows[idx].imm_u;
        ifence     <= rows[idx].ifence;
    endtask

    task automatic check_row(input int idx);
        row_t r;
        logic ok;
        r = rows[idx];
        ok = 1'b1;
        assert (reg_write_en === r.exp_wen) else begin
            $display("** Error at %0t ns: row %0d reg_write_en expected %0b, got %0b",
                     $time, idx, r.exp_wen, reg_write_en);
            ok = 1'b0;
        end
        if (r.chk_wdata) begin
            assert (reg_wdata === r.exp_wdata) else begin
                $display("** Error at %0t ns: row %0d reg_wdata expected %h, got %h",
                         $time, idx, r.exp_wdata, reg_wdata);
                ok = 1'b0;
            end
        end
        assert ((mal_load === r.exp_mal_load) && (mal_store === r.exp_mal_store)) else begin
            $display("** Error at %0t ns: row %0d mal flags expected %b%b, got %b%b",
                     $time, idx, r.exp_mal_load, r.exp_mal_store, mal_load, mal_store);
            ok = 1'b0;
        end
        assert ((iflush_pulses == int'(r.ifence)) && (dflush_pulses == int'(r.ifence))) else begin
            $display("** Error at %0t ns: row %0d flush pulses expected %0d, got %0d/%0d",
                     $time, idx, r.ifence, iflush_pulses, dflush_pulses);
            ok = 1'b0;
        end
        if (r.ifence) begin
            assert (idone_seen && ddone_seen) else begin
                $display("Row %0d: stall fell before both flush done signals arrived", idx);
                ok = 1'b0;
            end
        end
        if (ok) begin
            pass_count++;
            $display("row %0d %s: ok", idx, row_name[idx]);
        end else begin
            fail_count++;
            $display("row %0d %s: mismatch", idx, row_name[idx]);
        end
    endtask

    // Cache side: each done comes 1 to 6 cycles after the pulse
    initial begin
        int i_delay;
        int d_delay;
        seed = 32'h86a9;
        iflush_done = 1'b0;
        dflush_done = 1'b0;
        forever begin
            @(negedge CLK);
            if (icache_flush && dcache_flush) begin
                i_delay = 1 + ($unsigned($random(seed)) % 6);
                d_delay = 1 + ($unsigned($random(seed)) % 6);
                for (int c = 1; c <= ((i_delay > d_delay) ? i_delay : d_delay); c++) begin
                    @(posedge CLK);
                    iflush_done <= (c == i_delay);
                    dflush_done <= (c == d_delay);
                end
                @(posedge CLK);
                iflush_done <= 1'b0;
                dflush_done <= 1'b0;
            end
        end
    end

    always @(negedge CLK) begin
        if (icache_flush) begin
            iflush_pulses++;
        end
        if (dcache_flush) begin
            dflush_pulses++;
        end
        if (iflush_done) begin
            idone_seen = 1'b1;
        end
        if (dflush_done) begin
            ddone_seen = 1'b1;
        end
    end

    initial begin
        cycle_count = 0;
        @(posedge CLK);
        while (cycle_count < timeout_limit) begin
            @(posedge CLK);
            cycle_count++;
        end
        $display("Timeout after %0d cycles: stall never fell", cycle_count);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        nRST       = 1'b0;
        valid      = 1'b0;
        dren       = 1'b0;
        dwen       = 1'b0;
        load_type  = rv32_isa_pkg::NONE;
        addr       = 32'h0;
        store_data = 32'h0;
        w_sel      = rv32_isa_pkg::W_SEL_ALU;
        pc4        = 32'h0;
        imm_u      = 32'h0;
        ifence     = 1'b0;
        n_rows     = 0;
        pass_count = 0;
        fail_count = 0;
        build_table();
        timeout_limit = n_rows * (ACK_DELAY + 16) + 16 + 100;

        repeat (16) @(posedge CLK);
        nRST <= 1'b1;
        @(negedge CLK);
        assert (!UUT.req && !stall && !icache_flush && !dcache_flush && !reg_write_en
                && !mal_load && !mal_store) else begin
            $display("** Error at %0t ns: outputs not idle after reset", $time);
            fail_count++;
        end

        for (int i = 0; i < n_rows; i++) begin
            @(posedge CLK);
            drive_row(i);
            iflush_pulses = 0;
            dflush_pulses = 0;
            idone_seen = 1'b0;
            ddone_seen = 1'b0;
            @(negedge CLK);
            while (stall) begin
                @(negedge CLK);
            end
            check_row(i);
            @(posedge CLK);
            valid  <= 1'b0;
            dren   <= 1'b0;
            dwen   <= 1'b0;
            ifence <= 1'b0;
        end

        @(posedge CLK);
        $display("Summary: %0d rows passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
logic/rv32_isa_pkg.sv
logic/dbus_pkg.sv
logic/load_extender.sv
logic/fence_tracker.sv
logic/dbus_master.sv
logic/mem_stage.sv
logic/scratchpad_ram.sv
logic/mem_subsystem.sv
verif/mem_subsystem_tb.sv

// ==== Bender.yml ====
package:
  name: mem_subsystem

sources:
  - logic/rv32_isa_pkg.sv
  - logic/dbus_pkg.sv
  - logic/load_extender.sv
  - logic/fence_tracker.sv
  - logic/dbus_master.sv
  - logic/mem_stage.sv
  - logic/scratchpad_ram.sv
  - logic/mem_subsystem.sv
  - target: test
    files:
      - verif/mem_subsystem_tb.sv
